//--- src/scope_pkg.sv
//------------------------------
// Scope capture shared types
// Buffer widths, sample word layout and trigger encodings
//------------------------------

package scope_pkg;

  //------------------------------
  // Buffer geometry
  //------------------------------
  localparam int ADDR_BITS   = 13;               // 8K sample words
  localparam int BUFFER_SIZE = 1 << ADDR_BITS;

  typedef logic [ADDR_BITS-1:0] addr_t;          // Circular buffer address
  typedef logic [7:0]           adc_byte_t;      // One raw ADC conversion

  // Lane positions used by the trigger channel select
  localparam int TRIG_LANE_CH1 = 0;              // ch1 A
  localparam int TRIG_LANE_CH2 = 2;              // ch2 A

  //------------------------------
  // Sample word
  //------------------------------
  // Flat view goes into memory, lane view is used for trigger and checks
  // Lane order from LSB is ch1 A, ch1 B, ch2 A, ch2 B
  typedef union packed {
    logic [31:0]          word;
    adc_byte_t [3:0]      lane;
  } sample_word_u;

  typedef logic [31:0] tb_count_t;               // Time base limit for auto mode

  //------------------------------
  // Trigger settings
  //------------------------------
  typedef enum logic {
    TRIG_RISING  = 1'b0,
    TRIG_FALLING = 1'b1
  } trig_edge_e;

  // Auto mode stops on time base timeout when no trigger shows up
  typedef enum logic {
    TRIG_AUTO   = 1'b0,
    TRIG_NORMAL = 1'b1
  } trig_mode_e;

endpackage

//--- src/sample_buffer.sv
//------------------------------
// Sample buffer
// Circular dual port memory, one 32-bit word per sample clock
// Read port is registered and always active
//------------------------------

`timescale 1ns/1ps

module sample_buffer
#(
  parameter int ADDR_BITS = scope_pkg::ADDR_BITS      // Depth is 2**ADDR_BITS words
)
(
  input  logic                    i_sample_write_clock,
  input  logic                    i_write_enable,       // High while capture runs
  input  logic [ADDR_BITS-1:0]    i_write_address,
  input  scope_pkg::sample_word_u i_write_data,         // Four ADC lanes
  input  logic [ADDR_BITS-1:0]    i_read_address,
  output scope_pkg::sample_word_u o_read_data           // Valid one cycle after address
);

  localparam int DEPTH = 1 << ADDR_BITS;

  // Memory holds the flat view of the word
  logic [31:0] mem [DEPTH];

  //------------------------------
  // Write side
  //------------------------------
  always_ff @(posedge i_sample_write_clock)
  begin
    if (i_write_enable)
    begin
      mem[i_write_address] <= i_write_data.word;        // Address wraps on its own
    end
  end

  //------------------------------
  // Read side
  //------------------------------
  // Same clock as the writer, so a read of the address being written
  // returns the old contents
  always_ff @(posedge i_sample_write_clock)
  begin
    o_read_data <= mem[i_read_address];
  end

endmodule

//--- src/trigger_detector.sv
//------------------------------
// Trigger detector
// Level crossing check on the selected channel
// Sticky flag until reset
//------------------------------

`timescale 1ns/1ps

module trigger_detector
(
  input  logic                    i_sample_write_clock,
  input  logic                    i_sample_system_reset,
  input  scope_pkg::sample_word_u i_adc_word,      // Live ADC word
  input  logic                    i_channel,       // 0 = ch1 A, 1 = ch2 A
  input  scope_pkg::trig_edge_e   i_edge,
  input  scope_pkg::adc_byte_t    i_level,
  input  logic                    i_check_enable,  // From acquisition control
  output logic                    o_triggered
);

  import scope_pkg::*;

  adc_byte_t lane_sel;         // Selected trigger lane of the live word
  adc_byte_t trig_current;     // Sample n
  adc_byte_t trig_previous;    // Sample n-1
  logic      prev_below;
  logic      cur_below;
  logic      rise_detect;
  logic      fall_detect;
  logic      crossing;

  assign lane_sel = i_channel ? i_adc_word.lane[TRIG_LANE_CH2]
                              : i_adc_word.lane[TRIG_LANE_CH1];

  //------------------------------
  // Sample pipeline
  //------------------------------
  always_ff @(posedge i_sample_write_clock)
  begin
    if (i_sample_system_reset)
    begin
      trig_previous <= '0;
      trig_current  <= '0;
    end
    else
    begin
      trig_previous <= trig_current;   // Shift the older sample down
      trig_current  <= lane_sel;
    end
  end

  //------------------------------
  // Level compare
  //------------------------------
  assign prev_below = trig_previous < i_level;
  assign cur_below  = trig_current  < i_level;

  // Rising means below then at or above the level
  assign rise_detect = prev_below & ~cur_below;
  // Falling is the mirror case
  assign fall_detect = ~prev_below & cur_below;

  assign crossing = (i_edge == TRIG_RISING) ? rise_detect : fall_detect;

  // Flag holds until the next capture reset
  always_ff @(posedge i_sample_write_clock)
  begin
    if (i_sample_system_reset)
    begin
      o_triggered <= 1'b0;
    end
    else if (i_check_enable && crossing)
    begin
      o_triggered <= 1'b1;
    end
  end

endmodule

//--- src/acquisition_control.sv
//------------------------------
// Acquisition control
// Write address, pretrigger fill, time base and stop logic
// Also captures the trigger position in the buffer
//------------------------------

`timescale 1ns/1ps

module acquisition_control
#(
  parameter int ADDR_BITS = scope_pkg::ADDR_BITS
)
(
  input  logic                  i_sample_write_clock,
  input  logic                  i_sample_system_reset,
  input  scope_pkg::trig_mode_e i_mode,
  input  logic [ADDR_BITS-1:0]  i_pretrigger,        // Samples kept before the trigger
  input  logic [ADDR_BITS-1:0]  i_total,             // Pretrigger plus post-trigger
  input  scope_pkg::tb_count_t  i_time_base_set,     // Auto mode timeout
  input  logic                  i_triggered,         // Sticky flag from the detector
  output logic [ADDR_BITS-1:0]  o_write_address,
  output logic                  o_write_enable,
  output logic                  o_check_enable,
  output logic                  o_sampling_done,
  output logic [ADDR_BITS-1:0]  o_trigger_address
);

  import scope_pkg::*;

  logic [ADDR_BITS-1:0] trigger_read_address;  // Lags the write address by one
  logic [ADDR_BITS-1:0] post_trigger_len;
  logic [ADDR_BITS-1:0] post_trigger_dist;
  logic                 half_way;              // Pretrigger region filled
  tb_count_t            time_base_cnt;
  logic                 time_base_timeout;
  logic                 auto_timeout;
  logic                 post_trigger_done;

  //------------------------------
  // Write address counter
  //------------------------------
  always_ff @(posedge i_sample_write_clock)
  begin
    if (i_sample_system_reset)
      o_write_address <= '0;
    else if (o_write_enable)
      o_write_address <= o_write_address + 1'b1;   // Wraps around the buffer
  end

  // Set once sample P has been written, so the oldest compared
  // sample lies past the pretrigger fill
  always_ff @(posedge i_sample_write_clock)
  begin
    if (i_sample_system_reset)
      half_way <= 1'b0;
    else if (o_write_address > i_pretrigger)
      half_way <= 1'b1;
  end

  assign o_check_enable = half_way & ~i_triggered;

  //------------------------------
  // Trigger read counter
  //------------------------------
  // Preload of P+1 lines it up with the detector pipeline delay
  always_ff @(posedge i_sample_write_clock)
  begin
    if (i_sample_system_reset)
      trigger_read_address <= i_pretrigger + 1'b1;
    else if (half_way && o_write_enable)
      trigger_read_address <= trigger_read_address + 1'b1;
  end

  //------------------------------
  // Time base
  //------------------------------
  always_ff @(posedge i_sample_write_clock)
  begin
    if (i_sample_system_reset)
      time_base_cnt <= '0;
    else
      time_base_cnt <= time_base_cnt + 1'b1;       // Cycles since reset
  end

  assign time_base_timeout = time_base_cnt > i_time_base_set;
  assign auto_timeout      = (i_mode == TRIG_AUTO) & ~i_triggered & time_base_timeout;

  //------------------------------
  // Stop condition
  //------------------------------
  // Distance is taken modulo the buffer depth
  assign post_trigger_len  = i_total - i_pretrigger;
  assign post_trigger_dist = o_write_address - o_trigger_address;
  assign post_trigger_done = i_triggered & (post_trigger_dist >= post_trigger_len);

  always_ff @(posedge i_sample_write_clock)
  begin
    if (i_sample_system_reset)
      o_write_enable <= 1'b1;                      // Capture starts right away
    else if (post_trigger_done || auto_timeout)
      o_write_enable <= 1'b0;                      // Held off until next reset
  end

  assign o_sampling_done = ~o_write_enable;

  //------------------------------
  // Trigger address capture
  //------------------------------
  // Follows the read counter until the flag freezes it
  always_ff @(posedge i_sample_write_clock)
  begin
    if (i_sample_system_reset)
    begin
      o_trigger_address <= '0;
    end
    else if (!i_triggered)
    begin
      if (auto_timeout)
        o_trigger_address <= i_pretrigger;         // Free run, centre on P
      else
        o_trigger_address <= trigger_read_address;
    end
  end

endmodule

//--- src/scope_capture_top.sv
//------------------------------
// Scope capture top
// Sample buffer, trigger detector and acquisition control
//------------------------------

`timescale 1ns/1ps

module scope_capture_top
#(
  parameter int BUFFER_ADDR_BITS = scope_pkg::ADDR_BITS   // Buffer depth exponent
)
(
  input  logic                          i_sample_write_clock,
  input  logic                          i_sample_system_reset,  // Restarts a capture

  // ADC input and trigger setup
  input  scope_pkg::sample_word_u       i_adc_word,
  input  logic                          i_trig_channel,         // 0 = ch1 A, 1 = ch2 A
  input  scope_pkg::trig_edge_e         i_trig_edge,
  input  scope_pkg::trig_mode_e         i_trig_mode,
  input  scope_pkg::adc_byte_t          i_trig_level,

  // Capture window
  input  logic [BUFFER_ADDR_BITS-1:0]   i_pretrigger,           // P
  input  logic [BUFFER_ADDR_BITS-1:0]   i_total,                // T, above P
  input  scope_pkg::tb_count_t          i_time_base_set,        // S

  // Readback and status
  input  logic [BUFFER_ADDR_BITS-1:0]   i_read_address,
  output scope_pkg::sample_word_u       o_read_data,
  output logic                          o_triggered,
  output logic                          o_sampling_done,
  output logic [BUFFER_ADDR_BITS-1:0]   o_trigger_address
);

  //------------------------------
  // Internal wiring
  //------------------------------
  logic [BUFFER_ADDR_BITS-1:0] write_address;
  logic                        write_enable;
  logic                        check_enable;    // Detector may arm

  // Circular sample memory
  sample_buffer
  #(
    .ADDR_BITS (BUFFER_ADDR_BITS)
  )
  u_sample_buffer
  (
    .i_sample_write_clock (i_sample_write_clock),
    .i_write_enable       (write_enable),
    .i_write_address      (write_address),
    .i_write_data         (i_adc_word),
    .i_read_address       (i_read_address),
    .o_read_data          (o_read_data)
  );

  // Edge detector on the live samples
  trigger_detector u_trigger_detector
  (
    .i_sample_write_clock  (i_sample_write_clock),
    .i_sample_system_reset (i_sample_system_reset),
    .i_adc_word            (i_adc_word),
    .i_channel             (i_trig_channel),
    .i_edge                (i_trig_edge),
    .i_level               (i_trig_level),
    .i_check_enable        (check_enable),
    .o_triggered           (o_triggered)
  );

  // Addressing, timeout and stop
  acquisition_control
  #(
    .ADDR_BITS (BUFFER_ADDR_BITS)
  )
  u_acquisition_control
  (
    .i_sample_write_clock  (i_sample_write_clock),
    .i_sample_system_reset (i_sample_system_reset),
    .i_mode                (i_trig_mode),
    .i_pretrigger          (i_pretrigger),
    .i_total               (i_total),
    .i_time_base_set       (i_time_base_set),
    .i_triggered           (o_triggered),
    .o_write_address       (write_address),
    .o_write_enable        (write_enable),
    .o_check_enable        (check_enable),
    .o_sampling_done       (o_sampling_done),
    .o_trigger_address     (o_trigger_address)
  );

endmodule

//--- verif/tb_scope_capture.sv
//------------------------------
// Scope capture testbench
// Ramp stimulus around the trigger level, predicted trigger and stop
// points, status compare per cycle and buffer readback
//------------------------------

`timescale 1ns/1ps

module tb_scope_capture;

  import scope_pkg::*;

  localparam int CLK_PERIOD   = 40;
  localparam int DRIVE_DELAY  = 2;          // Inputs move just after the edge
  localparam int RESET_CYCLES = 8;
  localparam int MAX_SAMPLES  = 512;        // Longest capture of any test
  localparam int NUM_TESTS    = 4;
  localparam int WATCHDOG_CYCLES = NUM_TESTS * (RESET_CYCLES + MAX_SAMPLES + 4) + MAX_SAMPLES + 16;
  localparam int HIGH_SPAN    = 16;         // Samples on the far side between two crossings
  localparam int LEVEL        = 128;
  localparam int LANE_RANDOM  = 0;
  localparam int LANE_RAMP    = 1;
  localparam int LANE_FLAT    = 2;

  typedef struct packed {
    bit    found;        // Trigger lands before the stop
    addr_t trig_index;   // Expected trigger address
    addr_t last_addr;    // Last address written
  } capture_expect_t;

  logic            sample_write_clock;
  logic            sample_system_reset;
  sample_word_u    adc_word;
  logic            trig_channel;
  trig_edge_e      trig_edge;
  trig_mode_e      trig_mode;
  adc_byte_t       trig_level;
  addr_t           pretrigger;
  addr_t           total;
  tb_count_t       time_base_set;
  addr_t           read_address;
  sample_word_u    read_data;
  logic            triggered;
  logic            sampling_done;
  addr_t           trigger_address;

  integer          seed = 74967;
  sample_word_u    stim [MAX_SAMPLES];     // Word for each cycle index
  capture_expect_t expected;
  string           test_name;
  int              cycle_idx;              // Edge number since reset release
  bit              monitor_on;
  int              check_count;
  int              mismatch_count;
  int              failure_count;

  scope_capture_top #(.BUFFER_ADDR_BITS(ADDR_BITS)) dut
  (
    .i_sample_write_clock  (sample_write_clock),
    .i_sample_system_reset (sample_system_reset),
    .i_adc_word            (adc_word),
    .i_trig_channel        (trig_channel),
    .i_trig_edge           (trig_edge),
    .i_trig_mode           (trig_mode),
    .i_trig_level          (trig_level),
    .i_pretrigger          (pretrigger),
    .i_total               (total),
    .i_time_base_set       (time_base_set),
    .i_read_address        (read_address),
    .o_read_data           (read_data),
    .o_triggered           (triggered),
    .o_sampling_done       (sampling_done),
    .o_trigger_address     (trigger_address)
  );

  initial
  begin
    sample_write_clock = 1'b0;
    forever #(CLK_PERIOD / 2) sample_write_clock = ~sample_write_clock;
  end

  //------------------------------
  // Compare tasks
  //------------------------------
  task automatic check_flag(input string name, input bit exp, input logic act);
    check_count++;
    if (act !== exp)
    begin
      mismatch_count++;
      $display("mismatch %s: expected %0b actual %0b", name, exp, act);
    end
  endtask

  task automatic check_addr(input string name, input addr_t exp, input addr_t act);
    check_count++;
    if (act !== exp)
    begin
      mismatch_count++;
      $display("mismatch %s: expected %0d actual %0d", name, exp, act);
    end
  endtask

  task automatic check_word(input string name, input sample_word_u exp, input sample_word_u act);
    check_count++;
    if (act !== exp)
    begin
      mismatch_count++;
      $display("mismatch %s: expected %08h actual %08h", name, exp.word, act.word);
    end
  endtask

  task automatic report_counts();
    $display("checks %0d, mismatches %0d, other errors %0d",
             check_count, mismatch_count, failure_count);
  endtask

  //------------------------------
  // Stimulus shaping
  //------------------------------
  // Sawtooth under the level that climbs to the crossing, noise on top
  function automatic adc_byte_t ramp_value(input int i, input bit falling,
                                           input int c1, input int c2);
    int next_cross;
    int v;
    bit above;
    above = (i >= c1 && i < c1 + HIGH_SPAN) || (i >= c2);
    if (above)
      v = LEVEL + ($random(seed) & 63);
    else
    begin
      next_cross = (i < c1) ? c1 : c2;
      v = LEVEL - 1 - ((next_cross - 1 - i) & 63) - ($random(seed) & 7);
    end
    if (falling)
      v = 2 * LEVEL - 1 - v;                 // Mirror around the level
    return adc_byte_t'(v);
  endfunction

  task automatic shape_lane(input int lane_idx, input int kind, input bit falling,
                            input int c1, input int c2);
    int i;
    for (i = 0; i < MAX_SAMPLES; i++)
    begin
      case (kind)
        LANE_RAMP: stim[i].lane[lane_idx] = ramp_value(i, falling, c1, c2);
        LANE_FLAT: stim[i].lane[lane_idx] = adc_byte_t'(LEVEL - 30);  // Quiet, under level
        default:   stim[i].lane[lane_idx] = adc_byte_t'($random(seed));
      endcase
    end
  endtask

  // B lanes are never trigger sources, so they stay random
  task automatic build_stimulus(input int kind_a1, input bit fall_a1, input int c1_a1,
                                input int c2_a1, input int kind_a2, input bit fall_a2,
                                input int c1_a2, input int c2_a2);
    shape_lane(0, kind_a1, fall_a1, c1_a1, c2_a1);
    shape_lane(1, LANE_RANDOM, 1'b0, 0, 0);
    shape_lane(2, kind_a2, fall_a2, c1_a2, c2_a2);
    shape_lane(3, LANE_RANDOM, 1'b0, 0, 0);
  endtask

  //------------------------------
  // Reference model
  //------------------------------
  function automatic capture_expect_t predict_capture(
    input sample_word_u samples [MAX_SAMPLES],
    input addr_t        p,
    input addr_t        t,
    input tb_count_t    s,
    input trig_mode_e   mode,
    input trig_edge_e   edge_sel,
    input bit           ch,
    input adc_byte_t    level
  );
    capture_expect_t r;
    int              n;
    int              limit;
    int              lane_idx;
    adc_byte_t       prev;
    adc_byte_t       cur;
    bit              hit;
    r.found      = 1'b0;
    r.trig_index = p;                        // Auto timeout reports P
    r.last_addr  = addr_t'(s + 1);
    lane_idx     = ch ? 2 : 0;               // ch2 A or ch1 A
    limit        = MAX_SAMPLES - 1;
    if (mode == TRIG_AUTO && int'(s) - 1 < limit)
      limit = int'(s) - 1;                   // Flag has to beat the timeout edge
    for (n = int'(p) + 1; n <= limit && !r.found; n++)
    begin
      prev = samples[n - 1].lane[lane_idx];
      cur  = samples[n].lane[lane_idx];
      if (edge_sel == TRIG_RISING)
        hit = (prev < level) && (cur >= level);
      else
        hit = (prev >= level) && (cur < level);
      if (hit)
      begin
        r.found      = 1'b1;
        r.trig_index = addr_t'(n);
        // Post-trigger region end, wrapped at the buffer depth
        r.last_addr  = addr_t'((n + int'(t) - int'(p)) % BUFFER_SIZE);
      end
    end
    return r;
  endfunction

  // Status compare on every falling edge of a running capture
  always @(negedge sample_write_clock)
  begin
    if (monitor_on)
    begin
      check_flag({test_name, " triggered"},
                 expected.found && (cycle_idx > int'(expected.trig_index)), triggered);
      check_flag({test_name, " sampling_done"},
                 cycle_idx >= int'(expected.last_addr), sampling_done);
    end
  end

  //------------------------------
  // Capture and readback
  //------------------------------
  task automatic run_capture(input string name, input int p, input int t, input int s,
                             input trig_mode_e mode, input trig_edge_e edge_sel,
                             input bit ch, input int intended);
    int n;
    int tail;
    int ref_index;
    test_name = name;
    @(posedge sample_write_clock);
    #DRIVE_DELAY;
    sample_system_reset = 1'b1;
    trig_mode     = mode;
    trig_edge     = edge_sel;
    trig_channel  = ch;
    pretrigger    = addr_t'(p);
    total         = addr_t'(t);
    time_base_set = tb_count_t'(s);
    expected  = predict_capture(stim, pretrigger, total, time_base_set, mode, edge_sel, ch,
                                trig_level);
    ref_index = expected.found ? int'(expected.trig_index) : -1;
    if (ref_index != intended)
    begin
      failure_count++;
      $display("%s: stimulus crossing placed at %0d but reference found %0d",
               name, intended, ref_index);
    end
    repeat (RESET_CYCLES) @(posedge sample_write_clock);
    #DRIVE_DELAY;
    sample_system_reset = 1'b0;
    adc_word   = stim[0];                     // Sample 0 goes in at the next edge
    cycle_idx  = -1;
    monitor_on = 1'b1;
    tail       = 0;
    for (n = 0; n < MAX_SAMPLES - 1 && tail < 3; n++)
    begin
      @(posedge sample_write_clock);
      #DRIVE_DELAY;
      cycle_idx = n;
      adc_word  = stim[n + 1];
      if (sampling_done === 1'b1)
        tail++;                               // Watch a few cycles past done
    end
    @(negedge sample_write_clock);
    #1;
    monitor_on = 1'b0;
    if (tail == 0)
    begin
      failure_count++;
      $display("%s: sampling done never rose within %0d samples", name, MAX_SAMPLES);
    end
    check_addr({name, " trigger_address"}, expected.trig_index, trigger_address);
    check_flag({name, " final triggered"}, expected.found, triggered);
  endtask

  // Registered read port, one address per cycle
  task automatic readback(input string name, input int first, input int last);
    int a;
    @(posedge sample_write_clock);
    #DRIVE_DELAY;
    read_address = addr_t'(first);
    for (a = first; a <= last; a++)
    begin
      @(posedge sample_write_clock);
      #DRIVE_DELAY;
      check_word({name, $sformatf(" addr %0d", a)}, stim[a], read_data);
      read_address = addr_t'(a + 1);
    end
  endtask

  //------------------------------
  // Test sequence
  //------------------------------
  initial
  begin
    sample_system_reset = 1'b1;
    adc_word       = '0;
    trig_channel   = 1'b0;
    trig_edge      = TRIG_RISING;
    trig_mode      = TRIG_NORMAL;
    trig_level     = adc_byte_t'(LEVEL);
    pretrigger     = '0;
    total          = '0;
    time_base_set  = '0;
    read_address   = '0;
    monitor_on     = 1'b0;
    cycle_idx      = -1;
    check_count    = 0;
    mismatch_count = 0;
    failure_count  = 0;
    test_name      = "idle";

    // Rising crossing on ch1 A, then read the window back
    build_stimulus(LANE_RAMP, 1'b0, 150, 150, LANE_RANDOM, 1'b0, 0, 0);
    run_capture("rise_ch1", 64, 200, 1000, TRIG_NORMAL, TRIG_RISING, 1'b0, 150);
    readback("readback_rise_ch1", 64, int'(expected.last_addr));

    // Earlier ch1 fall must not count when ch2 is selected
    build_stimulus(LANE_RAMP, 1'b1, 90, 90, LANE_RAMP, 1'b1, 200, 200);
    run_capture("fall_ch2", 50, 120, 1000, TRIG_NORMAL, TRIG_FALLING, 1'b1, 200);

    // First crossing sits inside the pretrigger fill
    build_stimulus(LANE_RAMP, 1'b0, 40, 180, LANE_RANDOM, 1'b0, 0, 0);
    run_capture("pretrig_ignore", 100, 160, 1000, TRIG_NORMAL, TRIG_RISING, 1'b0, 180);

    // Auto mode times out on a quiet input
    build_stimulus(LANE_FLAT, 1'b0, 0, 0, LANE_FLAT, 1'b0, 0, 0);
    run_capture("auto_flat", 80, 300, 250, TRIG_AUTO, TRIG_RISING, 1'b0, -1);

    report_counts();
    if (mismatch_count == 0 && failure_count == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

  // Watchdog sized from the capture and readback bounds
  initial
  begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, the run hung in %s",
             WATCHDOG_CYCLES, test_name);
    report_counts();
    $display("test failed");
    $finish;
  end

endmodule

//--- files.f
src/scope_pkg.sv
src/sample_buffer.sv
src/trigger_detector.sv
src/acquisition_control.sv
src/scope_capture_top.sv
verif/tb_scope_capture.sv

//--- Bender.yml
package:
  name: scope_capture

sources:
  # Package first, then RTL leaves and the top level
  - src/scope_pkg.sv
  - src/sample_buffer.sv
  - src/trigger_detector.sv
  - src/acquisition_control.sv
  - src/scope_capture_top.sv

  # Testbench for scope_capture_top
  - target: test
    files:
      - verif/tb_scope_capture.sv
